// File: quantizer.f
+incdir+verif
source/quant_pkg.sv
source/quant_valid_pipe.sv
source/quant_input_stage.sv
source/quant_step_rom.sv
source/quant_mult_stage.sv
source/quant_round_stage.sv
source/quantizer.sv
verif/quantizer_tb.sv

// File: Bender.yml
package:
  name: quantizer

sources:
  - files:
      - source/quant_pkg.sv
      - source/quant_valid_pipe.sv
      - source/quant_input_stage.sv
      - source/quant_step_rom.sv
      - source/quant_mult_stage.sv
      - source/quant_round_stage.sv
      - source/quantizer.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/quantizer_tb.sv

// File: verif/quant_ref.svh
`ifndef QUANT_REF_SVH
`define QUANT_REF_SVH

// ------------------------------------------------------------
// expected quantizer output from the step tables
// ------------------------------------------------------------
function automatic int ref_step(input logic tab_b, input int row, input int col);
	int step;
	step = 512; // everything outside the low corner.
	if (row == 0) begin
		case (col)
			0: step = 16;
			1: step = 32;
			2: step = 64;
			3: step = tab_b ? 64 : 128;
			default: step = 512;
		endcase
	end else if (row == 1) begin
		case (col)
			0: step = 32;
			1: step = 64;
			2: step = tab_b ? 64 : 512;
			default: step = 512;
		endcase
	end else if (row == 2 && col == 0) begin
		step = 64;
	end else if (row == 4 && col == 4 && !tab_b) begin
		step = 16;
	end
	return step;
endfunction

// floor(c / step + 1/2) in the low coefficient bits.
function automatic coef_block_t ref_quantize(input logic tab_b, input coef_block_t d);
	coef_block_t res;
	int c;
	int step;
	int num;
	int den;
	int r;
	for (int i = 0; i < block_len; i++) begin
		c = $signed(d[i]);
		step = ref_step(tab_b, i / 8, i % 8);
		num = 2 * c + step;
		den = 2 * step;
		if (num >= 0) r = num / den;
		else r = -((-num + den - 1) / den); // division truncates, so round down by hand.
		res[i] = r[coef_w-1:0];
	end
	return res;
endfunction

`endif

// File: verif/quantizer_tb.sv
`timescale 1ns/1ps
`default_nettype none

module quantizer_tb import quant_pkg::*; ();

	localparam int clk_period   = 20;
	localparam int reset_cycles = 8;
	localparam int num_blocks   = 33;
	localparam int idle_cycles  = 6;
	localparam int watchdog_ns  = (2 * num_blocks + reset_cycles + idle_cycles + 20) * clk_period;

	logic        clk;
	logic        srst_n;
	logic        enable;
	quant_mode_e mode;
	coef_block_t dct;
	coef_block_t q;
	logic        valid;

	int          seed = 32'he834;
	int          cycle = 0;
	coef_block_t exp_q[$];
	int          due_q[$];
	coef_block_t exp_blk;
	coef_block_t last_exp = '0;
	coef_block_t blk;
	int          due;

	`include "quant_ref.svh"

	quantizer u_quantizer (
		.clk    (clk),
		.srst_n (srst_n),
		.enable (enable),
		.mode   (mode),
		.dct    (dct),
		.q      (q),
		.valid  (valid)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	always @(posedge clk) cycle <= cycle + 1; // edge count.

	// ------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------
	task automatic abort_run();
		$display("test failed");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("ERR %s expected 0x%h actual 0x%h", name, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_q_block(input coef_block_t e);
		for (int i = 0; i < block_len; i++) begin
			check_value($sformatf("q[%0d]", i), e[i], q[i]);
		end
	endtask

	task automatic send_block(input quant_mode_e m, input coef_block_t d);
		@(posedge clk);
		#1;
		enable = 1'b1;
		mode = m;
		dct = d;
		exp_q.push_back(ref_quantize(m == qm_table_b, d));
		due_q.push_back(cycle + 3); // sampled by the third edge after enable.
	endtask

	task automatic stop_sending();
		@(posedge clk);
		#1;
		enable = 1'b0;
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0) @(negedge clk);
	endtask

	task automatic random_block(output coef_block_t d);
		for (int i = 0; i < block_len; i++) begin
			d[i] = coef_w'($random(seed));
		end
	endtask

	// ------------------------------------------------------------
	// compare outputs mid-cycle
	// ------------------------------------------------------------
	always @(negedge clk) begin
		if (srst_n && valid) begin
			if (exp_q.size() == 0) begin
				$display("valid pulse seen with no block outstanding");
				abort_run();
			end
			exp_blk = exp_q.pop_front();
			due = due_q.pop_front();
			check_value("valid_cycle", due, cycle);
			check_q_block(exp_blk);
			last_exp = exp_blk;
		end
	end

	initial begin
		#(watchdog_ns);
		$display("watchdog expired before all blocks came out, the run hung");
		abort_run();
	end

	// ------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------
	initial begin
		srst_n = 1'b0;
		enable = 1'b0;
		mode = qm_table_a;
		dct = '0;
		repeat (reset_cycles) @(posedge clk);
		#1 srst_n = 1'b1;

		@(negedge clk); // idle after reset.
		check_value("valid", 0, valid);
		check_q_block('0);

		random_block(blk);
		send_block(qm_table_a, blk);
		stop_sending();
		wait_drain();

		for (int i = 0; i < block_len; i++) blk[i] = 11'd100;
		send_block(qm_table_b, blk);
		stop_sending();
		wait_drain();
		check_value("q[3]", 2, q[3]); // 100 over 64.
		check_value("q[10]", 2, q[10]);
		check_value("q[36]", 0, q[36]); // 100 over 512.

		for (int n = 0; n < 30; n++) begin
			random_block(blk);
			send_block(quant_mode_e'($random(seed) & 1), blk);
		end
		stop_sending();
		wait_drain();

		for (int i = 0; i < block_len; i++) begin
			blk[i] = (i % 3 == 0) ? -11'sd1024 : (i % 3 == 1) ? 11'sd1023 : 11'sd0;
		end
		blk[0] = -11'sd8; // half steps over 16.
		blk[36] = 11'sd8;
		send_block(qm_table_a, blk);
		stop_sending();
		wait_drain();
		check_value("q[0]", 0, q[0]);
		check_value("q[36]", 1, q[36]);

		repeat (idle_cycles) @(negedge clk);
		check_q_block(last_exp); // held while idle.

		if (exp_q.size() != 0) begin
			$display("blocks still outstanding at the end of the run");
			abort_run();
		end else begin
			$display("test passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: source/quantizer.sv
`timescale 1ns/1ps
`default_nettype none

module quantizer import quant_pkg::*; (
	input  wire              clk,
	input  wire              srst_n,
	input  wire              enable,
	input  wire quant_mode_e mode,
	input  wire coef_block_t dct,
	output wire coef_block_t q,
	output wire              valid
);

	logic [pipe_depth-1:0] stage_en;
	captured_block_t       captured;
	recip_block_t          recip;
	wide_block_t           product;

	// ----------------------------------------------------------
	// stage gating
	// ----------------------------------------------------------
	quant_valid_pipe u_valid_pipe (
		.clk      (clk),
		.srst_n   (srst_n),
		.enable   (enable),
		.stage_en (stage_en)
	);

	assign valid = stage_en[pipe_depth-1]; // lines up with q.

	// ----------------------------------------------------------
	// data path
	// ----------------------------------------------------------
	quant_input_stage u_input_stage (
		.clk      (clk),
		.srst_n   (srst_n),
		.enable   (enable),
		.mode     (mode),
		.dct      (dct),
		.captured (captured)
	);

	quant_step_rom u_step_rom (
		.mode  (captured.mode), // table follows the block.
		.recip (recip)
	);

	quant_mult_stage u_mult_stage (
		.clk      (clk),
		.srst_n   (srst_n),
		.load     (stage_en[0]),
		.captured (captured),
		.recip    (recip),
		.product  (product)
	);

	quant_round_stage u_round_stage (
		.clk     (clk),
		.srst_n  (srst_n),
		.load    (stage_en[1]),
		.product (product),
		.q       (q)
	);

endmodule

`default_nettype wire

// File: source/quant_round_stage.sv
`timescale 1ns/1ps
`default_nettype none

module quant_round_stage import quant_pkg::*; (
	input  wire              clk,
	input  wire              srst_n,
	input  wire              load,
	input  wire wide_block_t product,
	output coef_block_t      q
);

	coef_block_t q_next;

	// ----------------------------------------------------------
	// round half up and drop the fraction
	// ----------------------------------------------------------
	// integer part plus the top fraction bit.
	// -0.5 lands on 0 for negatives too.
	always_comb begin
		for (int i = 0; i < block_len; i++) begin
			q_next[i] = product[i][wide_w-1:frac_w] + coef_w'(product[i][frac_w-1]);
		end
	end

	// output register on the same edge as valid.
	always_ff @(posedge clk) begin
		if (!srst_n) begin
			q <= '0;
		end else if (load) begin
			q <= q_next;
		end
	end

endmodule

`default_nettype wire

// File: source/quant_mult_stage.sv
`timescale 1ns/1ps
`default_nettype none

module quant_mult_stage import quant_pkg::*; (
	input  wire                  clk,
	input  wire                  srst_n,
	input  wire                  load,
	input  wire captured_block_t captured,
	input  wire recip_block_t    recip,
	output wide_block_t          product
);

	wide_block_t lane_prod;

	// ----------------------------------------------------------
	// one signed multiplier per lane
	// ----------------------------------------------------------
	for (genvar i = 0; i < block_len; i++) begin : g_lane
		logic signed [wide_w+recip_w:0] full;

		// reciprocal is unsigned, so pad a zero sign bit.
		assign full = $signed(captured.data[i]) * $signed({1'b0, recip[i]});
		assign lane_prod[i] = full[wide_w-1:0]; // never exceeds 23 bits.
	end

	always_ff @(posedge clk) begin
		if (!srst_n) begin
			product <= '0;
		end else if (load) begin
			product <= lane_prod;
		end
	end

endmodule

`default_nettype wire

// File: source/quant_step_rom.sv
`timescale 1ns/1ps
`default_nettype none

module quant_step_rom import quant_pkg::*; (
	input  wire quant_mode_e mode,
	output recip_block_t     recip
);

	// whole table switches with the captured mode.
	always_comb begin
		if (mode == qm_table_b) begin
			recip = recip_table_b;
		end else begin
			recip = recip_table_a;
		end
	end

	// ----------------------------------------------------------
	// checks
	// ----------------------------------------------------------
	// steps are powers of two from 16 to 512.
	for (genvar i = 0; i < block_len; i++) begin : g_chk
		always_comb begin
			a_recip_legal : assert final (recip[i] inside
				{13'd256, 13'd128, 13'd64, 13'd32, 13'd8})
				else $error("step_rom: lane %0d holds reciprocal %0d", i, recip[i]);
		end
	end

endmodule

`default_nettype wire

// File: source/quant_input_stage.sv
`timescale 1ns/1ps
`default_nettype none

module quant_input_stage import quant_pkg::*; (
	input  wire             clk,
	input  wire             srst_n,
	input  wire             enable,
	input  wire quant_mode_e mode,
	input  wire coef_block_t dct,
	output captured_block_t captured
);

	wide_block_t dct_ext;

	// sign extension up to the product width.
	always_comb begin
		for (int i = 0; i < block_len; i++) begin
			dct_ext[i] = {{frac_w{dct[i][coef_w-1]}}, dct[i]};
		end
	end

	// mode is captured with its own block.
	always_ff @(posedge clk) begin
		if (!srst_n) begin
			captured <= '0;
		end else if (enable) begin
			captured.mode <= mode;
			captured.data <= dct_ext;
		end
	end

	// ----------------------------------------------------------
	// checks
	// ----------------------------------------------------------
	a_mode_known : assert property (
		@(posedge clk) disable iff (!srst_n) enable |-> !$isunknown(mode)
	) else $error("input_stage: mode unknown while enable is high");

endmodule

`default_nettype wire

// File: source/quant_valid_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module quant_valid_pipe import quant_pkg::*; (
	input  wire                   clk,
	input  wire                   srst_n,
	input  wire                   enable,
	output logic [pipe_depth-1:0] stage_en
);

	// bit 0 gates the multiplier stage.
	always_ff @(posedge clk) begin
		if (!srst_n) begin
			stage_en <= '0;
		end else begin
			stage_en <= {stage_en[pipe_depth-2:0], enable};
		end
	end

	// ----------------------------------------------------------
	// checks
	// ----------------------------------------------------------
	// last bit must mirror enable from three edges back.
	property p_valid_latency;
		@(posedge clk) disable iff (!srst_n)
		($past(srst_n, 3) && $past(srst_n, 2) && $past(srst_n, 1)) |->
			(stage_en[pipe_depth-1] == $past(enable, pipe_depth));
	endproperty

	a_valid_latency : assert property (p_valid_latency)
		else $error("valid_pipe: last stage bit out of step with enable");

endmodule

`default_nettype wire

// File: source/quant_pkg.sv
`default_nettype none

package quant_pkg;

	// ----------------------------------------------------------
	// widths and sizes
	// ----------------------------------------------------------
	localparam int coef_w     = 11;              // signed dct coefficient.
	localparam int frac_w     = 12;              // reciprocal scale is 4096.
	localparam int recip_w    = 13;
	localparam int wide_w     = coef_w + frac_w; // 23 bits.
	localparam int block_len  = 64;
	localparam int block_dim  = 8;               // rows and columns of a block.
	localparam int pipe_depth = 3;
	localparam int recip_scale = 1 << frac_w;

	// ----------------------------------------------------------
	// types
	// ----------------------------------------------------------
	typedef enum logic [0:0] {
		qm_table_a = 1'b0,
		qm_table_b = 1'b1
	} quant_mode_e;

	// lane index is row * 8 + column.
	typedef logic [block_len-1:0][coef_w-1:0]  coef_block_t;
	typedef logic [block_len-1:0][wide_w-1:0]  wide_block_t;
	typedef logic [block_len-1:0][recip_w-1:0] recip_block_t;

	typedef struct packed {
		quant_mode_e mode;
		wide_block_t data;
	} captured_block_t;

	// ----------------------------------------------------------
	// step tables
	// ----------------------------------------------------------
	// fine steps only in the low frequencies.
	function automatic int step_of(input quant_mode_e m, input int idx);
		int row;
		int col;
		int step;
		row = idx / block_dim;
		col = idx % block_dim;
		if (row == 0 && col < 3) step = 16 << col;             // 16, 32, 64.
		else if (row == 0 && col == 3) step = (m == qm_table_a) ? 128 : 64;
		else if (row == 1 && col < 2) step = 32 << col;        // 32, 64.
		else if (row == 1 && col == 2 && m == qm_table_b) step = 64;
		else if (row == 2 && col == 0) step = 64;
		else if (row == 4 && col == 4 && m == qm_table_a) step = 16;
		else step = 512;
		return step;
	endfunction

	function automatic recip_block_t build_recip_table(input quant_mode_e m);
		recip_block_t tab;
		for (int i = 0; i < block_len; i++) begin
			tab[i] = recip_w'(recip_scale / step_of(m, i));
		end
		return tab;
	endfunction

	localparam recip_block_t recip_table_a = build_recip_table(qm_table_a);
	localparam recip_block_t recip_table_b = build_recip_table(qm_table_b);

endpackage

`default_nettype wire
